// ==== hw/prf_pkg.sv ====
// ----------------------------------------
// prf_pkg
// sizes and shared payload types of the banked physical register file
// ----------------------------------------

`default_nettype none

package prf_pkg;

	// ----------------------------------------
	// register file sizes

	// physical registers in total
	parameter int PR_COUNT = 64;
	parameter int LOG_PR_COUNT = $clog2(PR_COUNT);

	// banks, selected by the low PR bits
	parameter int BANK_COUNT = 4;
	parameter int LOG_BANK_COUNT = $clog2(BANK_COUNT);

	// row inside a bank is the upper part of the PR
	parameter int ROW_BITS = LOG_PR_COUNT - LOG_BANK_COUNT;

	// ROB tag carried alongside each result
	parameter int LOG_ROB_ENTRIES = 6;

	// ----------------------------------------
	// payload types

	// one writeback as it arrives from a requester
	typedef struct packed {
		logic [31:0] data;
		logic [LOG_PR_COUNT-1:0] pr;
		logic [LOG_ROB_ENTRIES-1:0] rob_index;
	} wb_req_t;

	// one beat on a bank's writeback bus
	// bank is implied by the bus, so only the row is carried
	typedef struct packed {
		logic [31:0] data;
		logic [ROW_BITS-1:0] upper_pr;
		logic [LOG_ROB_ENTRIES-1:0] rob_index;
	} wb_bus_t;

endpackage

`default_nettype wire

// ==== hw/prf_read_arbiter.sv ====
// ----------------------------------------
// prf_read_arbiter
// grants up to two read requesters per bank, lowest index first
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module prf_read_arbiter #(
	parameter int RR_COUNT = 8,
	parameter int BANK_ID = 0
) (
	// read requests from all requesters
	input wire logic [RR_COUNT-1:0] req_valid_by_rr,
	input wire logic [RR_COUNT-1:0][prf_pkg::LOG_PR_COUNT-1:0] req_pr_by_rr,

	// per requester result in this bank
	output logic [RR_COUNT-1:0] ack_by_rr,
	output logic [RR_COUNT-1:0] port_by_rr,

	// read commands toward the bank
	output logic [1:0] read_en_by_port,
	output logic [1:0][prf_pkg::ROW_BITS-1:0] read_row_by_port
);

	// bank select value this instance answers to
	localparam logic [prf_pkg::LOG_BANK_COUNT-1:0] BANK_SEL =
		BANK_ID[prf_pkg::LOG_BANK_COUNT-1:0];

	// ----------------------------------------
	// fixed priority grant

	always_comb begin
		int unsigned granted;

		ack_by_rr = '0;
		port_by_rr = '0;
		read_en_by_port = '0;
		read_row_by_port = '0;
		granted = 0;

		// walk requesters from index 0 upward
		for (int i = 0; i < RR_COUNT; i++) begin
			// only requests whose low PR bits pick this bank count
			if (req_valid_by_rr[i]
				&& req_pr_by_rr[i][prf_pkg::LOG_BANK_COUNT-1:0] == BANK_SEL
				&& granted < 2) begin
				ack_by_rr[i] = 1'b1;
				// first match takes port 0, second takes port 1
				port_by_rr[i] = granted[0];
				read_en_by_port[granted[0]] = 1'b1;
				// row is the PR with the bank bits stripped
				read_row_by_port[granted[0]] =
					req_pr_by_rr[i][prf_pkg::LOG_PR_COUNT-1:prf_pkg::LOG_BANK_COUNT];
				granted = granted + 1;
			end
			// later matches fall through unacked and must retry
		end
	end

endmodule

`default_nettype wire

// ==== hw/prf_wb_arbiter.sv ====
// ----------------------------------------
// prf_wb_arbiter
// per requester writeback queues, round-robin write select per bank
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module prf_wb_arbiter #(
	parameter int WR_COUNT = 4,
	parameter int WB_QUEUE_DEPTH = 4
) (
	input wire logic CLK,
	input wire logic nRST,

	// writeback requests, already registered by the wrapper
	input wire logic [WR_COUNT-1:0] wb_valid_by_wr,
	input wire prf_pkg::wb_req_t [WR_COUNT-1:0] wb_req_by_wr,
	output logic [WR_COUNT-1:0] wb_ready_by_wr,

	// registered winner per bank, used as bus beat and bank write
	output logic [prf_pkg::BANK_COUNT-1:0] write_valid_by_bank,
	output prf_pkg::wb_bus_t [prf_pkg::BANK_COUNT-1:0] write_by_bank
);

	// queue depth is assumed a power of two so pointers wrap by overflow
	localparam int PTR_BITS = $clog2(WB_QUEUE_DEPTH);
	localparam int CNT_BITS = $clog2(WB_QUEUE_DEPTH + 1);
	localparam int WR_BITS = $clog2(WR_COUNT);
	// free entries needed for ready: two register delays plus current beat
	localparam int READY_SLACK = 3;

	prf_pkg::wb_req_t queue_mem [WR_COUNT][WB_QUEUE_DEPTH];
	logic [WR_COUNT-1:0][PTR_BITS-1:0] head_ptr;
	logic [WR_COUNT-1:0][PTR_BITS-1:0] tail_ptr;
	logic [WR_COUNT-1:0][CNT_BITS-1:0] count;
	logic [prf_pkg::BANK_COUNT-1:0][WR_BITS-1:0] last_winner;

	prf_pkg::wb_req_t [WR_COUNT-1:0] cand;
	logic [WR_COUNT-1:0] cand_valid;
	logic [WR_COUNT-1:0] granted;
	logic [WR_COUNT-1:0] push;
	logic [WR_COUNT-1:0] pop;
	logic [prf_pkg::BANK_COUNT-1:0] win_valid;
	logic [prf_pkg::BANK_COUNT-1:0][WR_BITS-1:0] win_idx;

	// ----------------------------------------
	// candidates and queue control

	always_comb begin
		for (int w = 0; w < WR_COUNT; w++) begin
			// empty queue lets the incoming request compete directly
			cand[w] = (count[w] == '0) ? wb_req_by_wr[w] : queue_mem[w][head_ptr[w]];
			cand_valid[w] = (count[w] != '0) || wb_valid_by_wr[w];
			// incoming result is stored unless it won straight through
			push[w] = wb_valid_by_wr[w] && !((count[w] == '0) && granted[w]);
			pop[w] = (count[w] != '0) && granted[w];
			wb_ready_by_wr[w] = (WB_QUEUE_DEPTH - int'(count[w])) >= READY_SLACK;
		end
	end

	// round-robin per bank, starting after that bank's last winner
	always_comb begin
		int unsigned idx;

		win_valid = '0;
		win_idx = '0;
		granted = '0;
		for (int b = 0; b < prf_pkg::BANK_COUNT; b++) begin
			for (int k = 1; k <= WR_COUNT; k++) begin
				idx = (int'(last_winner[b]) + k) % WR_COUNT;
				if (!win_valid[b] && cand_valid[idx]
					&& cand[idx].pr[prf_pkg::LOG_BANK_COUNT-1:0]
						== b[prf_pkg::LOG_BANK_COUNT-1:0]) begin
					win_valid[b] = 1'b1;
					win_idx[b] = idx[WR_BITS-1:0];
					// a head targets one bank, so it wins at most once
					granted[idx] = 1'b1;
				end
			end
		end
	end

	// ----------------------------------------
	// state

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			head_ptr <= '0;
			tail_ptr <= '0;
			count <= '0;
			last_winner <= '0;
			write_valid_by_bank <= '0;
		end else begin
			for (int w = 0; w < WR_COUNT; w++) begin
				if (push[w]) tail_ptr[w] <= tail_ptr[w] + 1'b1;
				if (pop[w]) head_ptr[w] <= head_ptr[w] + 1'b1;
				if (push[w] && !pop[w]) count[w] <= count[w] + 1'b1;
				else if (!push[w] && pop[w]) count[w] <= count[w] - 1'b1;
			end
			for (int b = 0; b < prf_pkg::BANK_COUNT; b++) begin
				if (win_valid[b]) last_winner[b] <= win_idx[b];
			end
			write_valid_by_bank <= win_valid;
		end
	end

	// queue storage and bus payload
	always_ff @(posedge CLK) begin
		for (int w = 0; w < WR_COUNT; w++) begin
			if (push[w]) queue_mem[w][tail_ptr[w]] <= wb_req_by_wr[w];
		end
		for (int b = 0; b < prf_pkg::BANK_COUNT; b++) begin
			write_by_bank[b].data <= cand[win_idx[b]].data;
			write_by_bank[b].upper_pr <=
				cand[win_idx[b]].pr[prf_pkg::LOG_PR_COUNT-1:prf_pkg::LOG_BANK_COUNT];
			write_by_bank[b].rob_index <= cand[win_idx[b]].rob_index;
		end
	end

endmodule

`default_nettype wire

// ==== hw/prf_bank.sv ====
// ----------------------------------------
// prf_bank
// one bank of PR storage, two registered reads, one write, forward bypass
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module prf_bank (
	input wire logic CLK,
	input wire logic nRST,

	// read ports from this bank's arbiter
	input wire logic [1:0] read_en_by_port,
	input wire logic [1:0][prf_pkg::ROW_BITS-1:0] read_row_by_port,

	// write command, same beat as the bus
	input wire logic write_valid,
	input wire prf_pkg::wb_bus_t write,

	// registered read results
	output logic [1:0][31:0] read_data_by_port,
	output logic [31:0] forward_data
);

	localparam int ROW_COUNT = prf_pkg::PR_COUNT / prf_pkg::BANK_COUNT;

	logic [31:0] mem [ROW_COUNT];
	logic fwd_hit;

	// write landing on the port 0 row at this edge
	assign fwd_hit = write_valid && read_en_by_port[0]
		&& (write.upper_pr == read_row_by_port[0]);

	// ----------------------------------------
	// storage

	// no init, a PR never written reads undefined
	always_ff @(posedge CLK) begin
		if (write_valid) mem[write.upper_pr] <= write.data;
	end

	// BRAM style read, old contents on a same edge write
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			read_data_by_port <= '0;
			forward_data <= '0;
		end else begin
			for (int p = 0; p < 2; p++) begin
				if (read_en_by_port[p]) read_data_by_port[p] <= mem[read_row_by_port[p]];
			end
			// forward path takes the new value when the rows collide
			if (read_en_by_port[0]) begin
				forward_data <= fwd_hit ? write.data : mem[read_row_by_port[0]];
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/prf_core.sv ====
// ----------------------------------------
// prf_core
// read arbiters, writeback arbiter and banks of the register file
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module prf_core #(
	parameter int RR_COUNT = 8,
	parameter int WR_COUNT = 4,
	parameter int WB_QUEUE_DEPTH = 4
) (
	input wire logic CLK,
	input wire logic nRST,

	// read requests
	input wire logic [RR_COUNT-1:0] reg_read_req_valid_by_rr,
	input wire logic [RR_COUNT-1:0][prf_pkg::LOG_PR_COUNT-1:0] reg_read_req_pr_by_rr,
	output logic [RR_COUNT-1:0] reg_read_ack_by_rr,
	output logic [RR_COUNT-1:0] reg_read_port_by_rr,
	output logic [prf_pkg::BANK_COUNT-1:0][1:0][31:0] reg_read_data_by_bank_by_port,

	// writeback requests
	input wire logic [WR_COUNT-1:0] wb_valid_by_wr,
	input wire prf_pkg::wb_req_t [WR_COUNT-1:0] wb_req_by_wr,
	output logic [WR_COUNT-1:0] wb_ready_by_wr,

	// bus and forward outputs
	output logic [prf_pkg::BANK_COUNT-1:0] wb_bus_valid_by_bank,
	output prf_pkg::wb_bus_t [prf_pkg::BANK_COUNT-1:0] wb_bus_by_bank,
	output logic [prf_pkg::BANK_COUNT-1:0][31:0] forward_data_by_bank
);

	logic [prf_pkg::BANK_COUNT-1:0][RR_COUNT-1:0] ack_by_bank_by_rr;
	logic [prf_pkg::BANK_COUNT-1:0][RR_COUNT-1:0] port_by_bank_by_rr;
	logic [prf_pkg::BANK_COUNT-1:0][1:0] read_en_by_bank_by_port;
	logic [prf_pkg::BANK_COUNT-1:0][1:0][prf_pkg::ROW_BITS-1:0] read_row_by_bank_by_port;

	// ----------------------------------------
	// read side

	for (genvar b = 0; b < prf_pkg::BANK_COUNT; b++) begin : g_read_arb
		prf_read_arbiter #(
			.RR_COUNT(RR_COUNT),
			.BANK_ID(b)
		) prf_read_arbiter_i (
			.req_valid_by_rr(reg_read_req_valid_by_rr),
			.req_pr_by_rr(reg_read_req_pr_by_rr),
			.ack_by_rr(ack_by_bank_by_rr[b]),
			.port_by_rr(port_by_bank_by_rr[b]),
			.read_en_by_port(read_en_by_bank_by_port[b]),
			.read_row_by_port(read_row_by_bank_by_port[b])
		);
	end

	// a requester targets one bank, so OR merges the per bank results
	always_comb begin
		reg_read_ack_by_rr = '0;
		reg_read_port_by_rr = '0;
		for (int b = 0; b < prf_pkg::BANK_COUNT; b++) begin
			reg_read_ack_by_rr = reg_read_ack_by_rr | ack_by_bank_by_rr[b];
			reg_read_port_by_rr = reg_read_port_by_rr | port_by_bank_by_rr[b];
		end
	end

	// ----------------------------------------
	// writeback side

	prf_wb_arbiter #(
		.WR_COUNT(WR_COUNT),
		.WB_QUEUE_DEPTH(WB_QUEUE_DEPTH)
	) prf_wb_arbiter_i (
		.CLK(CLK),
		.nRST(nRST),
		.wb_valid_by_wr(wb_valid_by_wr),
		.wb_req_by_wr(wb_req_by_wr),
		.wb_ready_by_wr(wb_ready_by_wr),
		.write_valid_by_bank(wb_bus_valid_by_bank),
		.write_by_bank(wb_bus_by_bank)
	);

	// ----------------------------------------
	// banks, write beat doubles as the bus beat

	for (genvar b = 0; b < prf_pkg::BANK_COUNT; b++) begin : g_bank
		prf_bank prf_bank_i (
			.CLK(CLK),
			.nRST(nRST),
			.read_en_by_port(read_en_by_bank_by_port[b]),
			.read_row_by_port(read_row_by_bank_by_port[b]),
			.write_valid(wb_bus_valid_by_bank[b]),
			.write(wb_bus_by_bank[b]),
			.read_data_by_port(reg_read_data_by_bank_by_port[b]),
			.forward_data(forward_data_by_bank[b])
		);
	end

endmodule

`default_nettype wire

// ==== hw/prf_wrapper.sv ====
// ----------------------------------------
// prf_wrapper
// top level, registers every input and output of the register file core
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module prf_wrapper #(
	parameter int RR_COUNT = 8,
	parameter int WR_COUNT = 4,
	parameter int WB_QUEUE_DEPTH = 4
) (
	input wire logic CLK,
	input wire logic nRST,

	// read requests by requester
	input wire logic [RR_COUNT-1:0] next_reg_read_req_valid_by_rr,
	input wire logic [RR_COUNT-1:0][prf_pkg::LOG_PR_COUNT-1:0] next_reg_read_req_pr_by_rr,

	// read grant by requester
	output logic [RR_COUNT-1:0] last_reg_read_ack_by_rr,
	output logic [RR_COUNT-1:0] last_reg_read_port_by_rr,

	// read data by bank and port
	output logic [prf_pkg::BANK_COUNT-1:0][1:0][31:0] last_reg_read_data_by_bank_by_port,

	// writeback by requester
	input wire logic [WR_COUNT-1:0] next_wb_valid_by_wr,
	input wire prf_pkg::wb_req_t [WR_COUNT-1:0] next_wb_req_by_wr,
	output logic [WR_COUNT-1:0] last_wb_ready_by_wr,

	// writeback bus by bank
	output logic [prf_pkg::BANK_COUNT-1:0] last_wb_bus_valid_by_bank,
	output prf_pkg::wb_bus_t [prf_pkg::BANK_COUNT-1:0] last_wb_bus_by_bank,

	// forward data by bank
	output logic [prf_pkg::BANK_COUNT-1:0][31:0] last_forward_data_by_bank
);

	// ----------------------------------------
	// core side signals

	logic [RR_COUNT-1:0] reg_read_req_valid_by_rr;
	logic [RR_COUNT-1:0][prf_pkg::LOG_PR_COUNT-1:0] reg_read_req_pr_by_rr;
	logic [RR_COUNT-1:0] reg_read_ack_by_rr;
	logic [RR_COUNT-1:0] reg_read_port_by_rr;
	logic [prf_pkg::BANK_COUNT-1:0][1:0][31:0] reg_read_data_by_bank_by_port;

	logic [WR_COUNT-1:0] wb_valid_by_wr;
	prf_pkg::wb_req_t [WR_COUNT-1:0] wb_req_by_wr;
	logic [WR_COUNT-1:0] wb_ready_by_wr;

	logic [prf_pkg::BANK_COUNT-1:0] wb_bus_valid_by_bank;
	prf_pkg::wb_bus_t [prf_pkg::BANK_COUNT-1:0] wb_bus_by_bank;
	logic [prf_pkg::BANK_COUNT-1:0][31:0] forward_data_by_bank;

	prf_core #(
		.RR_COUNT(RR_COUNT),
		.WR_COUNT(WR_COUNT),
		.WB_QUEUE_DEPTH(WB_QUEUE_DEPTH)
	) prf_core_i (.*);

	// ----------------------------------------
	// boundary registers

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			// inputs toward the core
			reg_read_req_valid_by_rr <= '0;
			reg_read_req_pr_by_rr <= '0;
			wb_valid_by_wr <= '0;
			wb_req_by_wr <= '0;

			// outputs, ready comes up high so requesters can start
			last_reg_read_ack_by_rr <= '0;
			last_reg_read_port_by_rr <= '0;
			last_reg_read_data_by_bank_by_port <= '0;
			last_wb_ready_by_wr <= '1;
			last_wb_bus_valid_by_bank <= '0;
			last_wb_bus_by_bank <= '0;
			last_forward_data_by_bank <= '0;
		end else begin
			// capture of the requests, edge E0
			reg_read_req_valid_by_rr <= next_reg_read_req_valid_by_rr;
			reg_read_req_pr_by_rr <= next_reg_read_req_pr_by_rr;
			wb_valid_by_wr <= next_wb_valid_by_wr;
			wb_req_by_wr <= next_wb_req_by_wr;

			// ack and port are combinational in the core, seen after E1
			last_reg_read_ack_by_rr <= reg_read_ack_by_rr;
			last_reg_read_port_by_rr <= reg_read_port_by_rr;

			// bank read registers add a cycle, seen after E2
			last_reg_read_data_by_bank_by_port <= reg_read_data_by_bank_by_port;
			last_forward_data_by_bank <= forward_data_by_bank;

			// ready follows queue occupancy one cycle late
			last_wb_ready_by_wr <= wb_ready_by_wr;

			// bus beats
			last_wb_bus_valid_by_bank <= wb_bus_valid_by_bank;
			last_wb_bus_by_bank <= wb_bus_by_bank;
		end
	end

endmodule

`default_nettype wire

// ==== bench/prf_tb_tasks.svh ====
// ----------------------------------------
// prf_tb helpers
// random numbers, reporting, stimulus drivers and bounded waits
// ----------------------------------------

`ifndef PRF_TB_TASKS_SVH
`define PRF_TB_TASKS_SVH

	// ----------------------------------------
	// random numbers and reporting

	// 32 bit xorshift, 13/17/5
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	task automatic report_mismatch(input string msg);
		$display("MISMATCH at time %0t: %s", $time, msg);
		error_count++;
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		error_count++;
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] want,
		input string what);
		check_count++;
		assert (got === want)
			else report_mismatch($sformatf("%s: got %h, expected %h", what, got, want));
	endtask

	task automatic finish_test(input string name);
		$display("test %s finished with %0d errors", name, error_count - test_errors_base);
		test_errors_base = error_count;
	endtask

	// ----------------------------------------
	// stimulus

	task automatic drive_idle();
		rd_valid = '0;
		wb_valid = '0;
	endtask

	// drive one writeback and remember the beat it owes
	task automatic send_wb(input int w, input logic [prf_pkg::LOG_PR_COUNT-1:0] pr);
		prf_pkg::wb_req_t req;
		logic [31:0] r;
		r = next_rand();
		req.data = next_rand();
		req.pr = pr;
		req.rob_index = r[prf_pkg::LOG_ROB_ENTRIES-1:0];
		wb_valid[w] = 1'b1;
		wb_req[w] = req;
		expect_q[w].push_back(req);
	endtask

	function automatic int queued_beats();
		int n;
		n = 0;
		for (int w = 0; w < WR_COUNT; w++) begin
			n += expect_q[w].size();
		end
		return n;
	endfunction

	// ----------------------------------------
	// bounded waits

	// idle until every expected beat has shown up
	task automatic wait_drain(input int limit);
		int n;
		n = 0;
		do begin
			step();
			drive_idle();
			n++;
		end while (queued_beats() != 0 && n < limit);
		if (queued_beats() != 0)
			report_failure($sformatf("timeout: %0d writebacks never reached a bus in %0d cycles",
				queued_beats(), limit));
	endtask

	task automatic wait_all_ready(input int limit);
		int n;
		n = 0;
		do begin
			step();
			drive_idle();
			n++;
		end while (ready != '1 && n < limit);
		if (ready != '1)
			report_failure($sformatf("timeout: writeback ready still low after %0d cycles", limit));
	endtask

	// read data shows three steps after the drive
	task automatic settle();
		for (int i = 0; i < 3; i++) begin
			step();
			drive_idle();
		end
	endtask

`endif

// ==== bench/prf_tb.sv ====
// ----------------------------------------
// prf_tb
// testbench for the banked register file, checks reads, arbitration,
// writeback beats, back-pressure and forward bypass against a model
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module prf_tb;

	localparam int RR_COUNT = 8;
	localparam int WR_COUNT = 4;
	localparam int BANKS = prf_pkg::BANK_COUNT;
	localparam int LB = prf_pkg::LOG_BANK_COUNT;
	localparam int PRW = prf_pkg::LOG_PR_COUNT;
	localparam int DRAIN_LIMIT = 400;
	localparam int READY_LIMIT = 50;
	localparam logic [31:0] SEED = 32'h7658;

	logic CLK = 1'b0;
	logic nRST;
	logic [RR_COUNT-1:0] rd_valid;
	logic [RR_COUNT-1:0][PRW-1:0] rd_pr;
	logic [WR_COUNT-1:0] wb_valid;
	prf_pkg::wb_req_t [WR_COUNT-1:0] wb_req;
	logic [RR_COUNT-1:0] ack;
	logic [RR_COUNT-1:0] port;
	logic [BANKS-1:0][1:0][31:0] rd_data;
	logic [WR_COUNT-1:0] ready;
	logic [BANKS-1:0] bus_valid;
	prf_pkg::wb_bus_t [BANKS-1:0] bus;
	logic [BANKS-1:0][31:0] fwd_data;

	logic [31:0] rng_state;
	int unsigned check_count;
	int unsigned error_count;
	int unsigned test_errors_base;
	int unsigned bypass_count;

	// register contents as last seen on the buses
	logic [31:0] model [prf_pkg::PR_COUNT];
	logic [prf_pkg::PR_COUNT-1:0] written;
	// beats still owed, per writeback requester in arrival order
	prf_pkg::wb_req_t expect_q [WR_COUNT][$];

	// reads driven one and two steps back
	logic [RR_COUNT-1:0] hist_valid [2];
	logic [RR_COUNT-1:0][PRW-1:0] hist_pr [2];

	// expected read and forward data, checked one step later
	logic [BANKS-1:0][1:0] snap_valid;
	logic [BANKS-1:0][1:0][31:0] snap_data;
	logic [BANKS-1:0] fwd_pending;
	logic [BANKS-1:0] fwd_valid;
	logic [BANKS-1:0][31:0] fwd_expect;
	logic [BANKS-1:0][prf_pkg::ROW_BITS-1:0] fwd_row;

	prf_wrapper #(
		.RR_COUNT(RR_COUNT),
		.WR_COUNT(WR_COUNT),
		.WB_QUEUE_DEPTH(4)
	) prf_wrapper_i (
		.CLK(CLK),
		.nRST(nRST),
		.next_reg_read_req_valid_by_rr(rd_valid),
		.next_reg_read_req_pr_by_rr(rd_pr),
		.last_reg_read_ack_by_rr(ack),
		.last_reg_read_port_by_rr(port),
		.last_reg_read_data_by_bank_by_port(rd_data),
		.next_wb_valid_by_wr(wb_valid),
		.next_wb_req_by_wr(wb_req),
		.last_wb_ready_by_wr(ready),
		.last_wb_bus_valid_by_bank(bus_valid),
		.last_wb_bus_by_bank(bus),
		.last_forward_data_by_bank(fwd_data)
	);

	// 4 ns clock
	always #2 CLK = ~CLK;

	// a port bit means nothing without its ack
	port_needs_ack: assert property (@(posedge CLK) disable iff (!nRST)
		(port & ~ack) == '0)
		else report_mismatch("port bit set on a requester that was not acked");

	`include "prf_tb_tasks.svh"

	// ----------------------------------------
	// monitors, run once per falling edge

	task automatic check_read_data();
		for (int b = 0; b < BANKS; b++) begin
			for (int p = 0; p < 2; p++) begin
				if (snap_valid[b][p])
					check_value(rd_data[b][p], snap_data[b][p],
						$sformatf("read data bank %0d port %0d", b, p));
			end
			if (fwd_pending[b] && fwd_valid[b])
				check_value(fwd_data[b], fwd_expect[b], $sformatf("forward data bank %0d", b));
		end
	endtask

	// two lowest matching requesters per bank win, in index order
	task automatic check_read_acks();
		logic [LB-1:0] bank;
		int unsigned rank;
		logic [PRW-1:0] pr;
		snap_valid = '0;
		fwd_pending = '0;
		for (int r = 0; r < RR_COUNT; r++) begin
			pr = hist_pr[1][r];
			bank = pr[LB-1:0];
			rank = 0;
			for (int q = 0; q < r; q++) begin
				if (hist_valid[1][q] && hist_pr[1][q][LB-1:0] == bank) rank++;
			end
			check_value(32'(ack[r]), 32'(hist_valid[1][r] && rank < 2),
				$sformatf("ack of requester %0d", r));
			check_value(32'(port[r]), 32'(hist_valid[1][r] && rank == 1),
				$sformatf("port of requester %0d", r));
			if (hist_valid[1][r] && rank < 2) begin
				// bank reads old contents on this edge
				snap_valid[bank][rank[0]] = written[pr];
				snap_data[bank][rank[0]] = model[pr];
				if (rank == 0) begin
					fwd_pending[bank] = 1'b1;
					fwd_valid[bank] = written[pr];
					fwd_expect[bank] = model[pr];
					fwd_row[bank] = pr[PRW-1:LB];
				end
			end
		end
	endtask

	// each beat must be the oldest owed beat of some requester
	task automatic check_beats();
		prf_pkg::wb_req_t head;
		logic found;
		logic [LB-1:0] bsel;
		for (int b = 0; b < BANKS; b++) begin
			bsel = b[LB-1:0];
			if (bus_valid[b]) begin
				found = 1'b0;
				for (int w = 0; w < WR_COUNT; w++) begin
					if (!found && expect_q[w].size() > 0) begin
						head = expect_q[w][0];
						if (head.pr == {bus[b].upper_pr, bsel} && head.data == bus[b].data
							&& head.rob_index == bus[b].rob_index) begin
							found = 1'b1;
							void'(expect_q[w].pop_front());
						end
					end
				end
				check_count++;
				assert (found)
					else report_mismatch($sformatf("bank %0d beat row %0d data %h rob %0d unexpected",
						b, bus[b].upper_pr, bus[b].data, bus[b].rob_index));
				if (found) begin
					model[{bus[b].upper_pr, bsel}] = bus[b].data;
					written[{bus[b].upper_pr, bsel}] = 1'b1;
					// write landed on the edge of a port 0 read of that row
					if (fwd_pending[b] && fwd_row[b] == bus[b].upper_pr) begin
						fwd_valid[b] = 1'b1;
						fwd_expect[b] = bus[b].data;
						bypass_count++;
					end
				end
			end
		end
	endtask

	task automatic step();
		@(negedge CLK);
		hist_valid[1] = hist_valid[0];
		hist_pr[1] = hist_pr[0];
		hist_valid[0] = rd_valid;
		hist_pr[0] = rd_pr;
		check_read_data();
		check_read_acks();
		check_beats();
	endtask

	// ----------------------------------------
	// test sequence

	initial begin
		logic [31:0] r;
		logic [PRW-1:0] pr;
		logic saw_low;
		int sent;
		int n;
		int unsigned bypass_base;

		rng_state = SEED;
		check_count = 0;
		error_count = 0;
		test_errors_base = 0;
		bypass_count = 0;
		written = '0;
		hist_valid[0] = '0;
		hist_valid[1] = '0;
		hist_pr[0] = '0;
		hist_pr[1] = '0;
		snap_valid = '0;
		fwd_pending = '0;
		fwd_valid = '0;
		nRST = 1'b0;
		rd_valid = '0;
		rd_pr = '0;
		wb_valid = '0;
		wb_req = '0;

		repeat (16) @(negedge CLK);
		nRST = 1'b1;

		// reset state
		step();
		check_value(32'(ack), 32'h0, "ack after reset");
		check_value(32'(port), 32'h0, "port after reset");
		check_value(32'(bus_valid), 32'h0, "bus valid after reset");
		check_value(32'(ready), 32'((1 << WR_COUNT) - 1), "ready after reset");
		for (int b = 0; b < BANKS; b++) begin
			check_value(rd_data[b][0], 32'h0, "port 0 data after reset");
			check_value(rd_data[b][1], 32'h0, "port 1 data after reset");
			check_value(fwd_data[b], 32'h0, "forward data after reset");
		end
		finish_test("reset state");

		// random writebacks, only while ready
		for (int i = 0; i < 200; i++) begin
			step();
			drive_idle();
			for (int w = 0; w < WR_COUNT; w++) begin
				r = next_rand();
				if (ready[w] && r[0]) send_wb(w, r[8:3]);
			end
		end
		wait_drain(DRAIN_LIMIT);
		finish_test("writeback delivery");

		// fill every PR, requester follows the bank so none contend
		pr = '0;
		sent = 0;
		n = 0;
		do begin
			step();
			drive_idle();
			if (ready[pr[LB-1:0]]) begin
				send_wb(int'(pr[LB-1:0]), pr);
				pr++;
				sent++;
			end
			n++;
		end while (sent < prf_pkg::PR_COUNT && n < DRAIN_LIMIT);
		if (sent < prf_pkg::PR_COUNT)
			report_failure($sformatf("timeout: only %0d of the PRs written in %0d cycles",
				sent, DRAIN_LIMIT));
		wait_drain(DRAIN_LIMIT);
		// then read each one back alone
		for (int p = 0; p < prf_pkg::PR_COUNT; p++) begin
			step();
			drive_idle();
			rd_valid[p % RR_COUNT] = 1'b1;
			rd_pr[p % RR_COUNT] = p[PRW-1:0];
		end
		settle();
		finish_test("read after write");

		// random reads from many requesters at once
		for (int i = 0; i < 150; i++) begin
			step();
			drive_idle();
			for (int q = 0; q < RR_COUNT; q++) begin
				r = next_rand();
				rd_valid[q] = (r[1:0] != 2'b00);
				rd_pr[q] = r[7:2];
			end
		end
		settle();
		finish_test("read arbitration");

		// every requester floods bank 0
		saw_low = 1'b0;
		for (int i = 0; i < 80; i++) begin
			step();
			drive_idle();
			if (ready != '1) saw_low = 1'b1;
			for (int w = 0; w < WR_COUNT; w++) begin
				r = next_rand();
				if (ready[w]) send_wb(w, {r[3:0], 2'b00});
			end
		end
		wait_drain(DRAIN_LIMIT);
		wait_all_ready(READY_LIMIT);
		check_count++;
		assert (saw_low) else report_failure("flooding one bank never lowered a writeback ready");
		finish_test("back-pressure");

		// write and port 0 read of one row meet at the bank edge
		bypass_base = bypass_count;
		for (int i = 0; i < 16; i++) begin
			step();
			drive_idle();
			r = next_rand();
			pr = r[PRW-1:0];
			send_wb(0, pr);
			step();
			drive_idle();
			rd_valid[0] = 1'b1;
			rd_pr[0] = pr;
			settle();
		end
		check_count++;
		assert (bypass_count - bypass_base == 16)
			else report_failure("a writeback did not meet its port 0 read at the bank edge");
		finish_test("forward bypass");

		settle();
		$display("tests 6, checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+bench
hw/prf_pkg.sv
hw/prf_read_arbiter.sv
hw/prf_wb_arbiter.sv
hw/prf_bank.sv
hw/prf_core.sv
hw/prf_wrapper.sv
bench/prf_tb.sv

// ==== Makefile ====
# Verilator build and run of the register file testbench

VERILATOR ?= verilator
TOP ?= prf_tb
FILELIST ?= sim.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

# sources come from the file list, headers are added by hand
SOURCES := $(shell grep -v '^+' $(FILELIST)) bench/prf_tb_tasks.svh
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass is decided from the log, not the exit status
run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
